//--- hw/aes_settings.svh
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

// Block and column geometry
`define AES_BLOCK_BITS 128
`define AES_WORD_BITS 32

// AES-128 round count
`define AES_ROUNDS 10

// Input register plus two cycles per round
`define AES_LATENCY 21

`endif

//--- hw/aesTypesPkg.sv
`include "aes_settings.svh"

package aesTypesPkg;

    //////////////////////////////////////////////////
    // Geometry derived from the block settings
    //////////////////////////////////////////////////
    localparam int BYTES_PER_WORD = `AES_WORD_BITS / 8;
    localparam int WORDS_PER_BLOCK = `AES_BLOCK_BITS / `AES_WORD_BITS;

    // One state byte
    typedef logic [7:0] aesByteT;

    // Column word, byte 0 most significant
    typedef aesByteT [0:BYTES_PER_WORD-1] aesWordT;

    // State or key block, word 0 most significant
    typedef aesWordT [0:WORDS_PER_BLOCK-1] aesBlockT;

endpackage

//--- hw/aesTablesPkg.sv
package aesTablesPkg;

    import aesTypesPkg::*;

    //////////////////////////////////////////////////
    // Forward S-box
    //////////////////////////////////////////////////
    localparam aesByteT SBOX [0:255] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    function automatic aesByteT sboxByte(input aesByteT b);
        return SBOX[b];
    endfunction

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic aesByteT xtime(input aesByteT b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // Rcon for key-expansion steps 1..10
    function automatic aesByteT roundConst(input int stepIndex);
        aesByteT rc;
        rc = 8'h01;
        for (int i = 1; i < stepIndex; i++)
        begin
            rc = xtime(rc);
        end
        return rc;
    endfunction

    function automatic aesWordT subWord(input aesWordT w);
        aesWordT result;
        for (int i = 0; i < BYTES_PER_WORD; i++)
        begin
            result[i] = sboxByte(w[i]);
        end
        return result;
    endfunction

endpackage

//--- hw/aesInitStage.sv
`timescale 1ns/1ps

module aesInitStage
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inValid,
    input  aesTypesPkg::aesBlockT plainText,
    input  aesTypesPkg::aesBlockT cipherKey,
    output aesTypesPkg::aesBlockT stateOut,
    output aesTypesPkg::aesBlockT keyOut,
    output logic                 validOut
);

    //////////////////////////////////////////////////
    // Whitening with the cipher key itself
    //////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        stateOut <= plainText ^ cipherKey;
        keyOut <= cipherKey;
    end

    // Block tag, dropped on reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            validOut <= 1'b0;
        end
        else
        begin
            validOut <= inValid;
        end
    end

endmodule

//--- hw/aesKeyStep.sv
`timescale 1ns/1ps

module aesKeyStep
#(
    parameter int STEP_INDEX = 1
)
(
    input  logic                 clk,
    input  aesTypesPkg::aesBlockT keyIn,
    output aesTypesPkg::aesBlockT keyOut,
    output aesTypesPkg::aesBlockT roundKey
);

    import aesTypesPkg::*;
    import aesTablesPkg::*;

    localparam aesByteT RCON = roundConst(STEP_INDEX);

    aesBlockT chain;
    aesBlockT chainReg;
    aesWordT rotWord;
    aesWordT subReg;

    //////////////////////////////////////////////////
    // First cycle
    //////////////////////////////////////////////////

    // Rcon goes into the top byte of word 0, then a running XOR
    always_comb
    begin
        chain[0] = keyIn[0];
        chain[0][0] = keyIn[0][0] ^ RCON;
        for (int w = 1; w < WORDS_PER_BLOCK; w++)
        begin
            chain[w] = chain[w-1] ^ keyIn[w];
        end
    end

    // RotWord of the last column
    assign rotWord = {keyIn[3][1], keyIn[3][2], keyIn[3][3], keyIn[3][0]};

    always_ff @(posedge clk)
    begin
        chainReg <= chain;
        subReg <= subWord(rotWord);
    end

    //////////////////////////////////////////////////
    // Second cycle
    //////////////////////////////////////////////////

    // Same substituted word folds into every column
    always_comb
    begin
        for (int w = 0; w < WORDS_PER_BLOCK; w++)
        begin
            roundKey[w] = chainReg[w] ^ subReg;
        end
    end

    always_ff @(posedge clk)
    begin
        keyOut <= roundKey;
    end

endmodule

//--- hw/aesRound.sv
`timescale 1ns/1ps

module aesRound
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 validIn,
    input  aesTypesPkg::aesBlockT stateIn,
    input  aesTypesPkg::aesBlockT roundKey,
    output aesTypesPkg::aesBlockT stateOut,
    output logic                 validOut
);

    import aesTypesPkg::*;
    import aesTablesPkg::*;

    aesBlockT sReg;
    aesBlockT dReg;
    aesBlockT mixed;
    logic validMid;

    //////////////////////////////////////////////////
    // Cycle 1: S-box and doubled S-box per byte
    //////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        for (int w = 0; w < WORDS_PER_BLOCK; w++)
        begin
            for (int b = 0; b < BYTES_PER_WORD; b++)
            begin
                sReg[w][b] <= sboxByte(stateIn[w][b]);
                dReg[w][b] <= xtime(sboxByte(stateIn[w][b]));
            end
        end
    end

    //////////////////////////////////////////////////
    // Cycle 2: ShiftRows, MixColumns, AddRoundKey
    //////////////////////////////////////////////////

    // Row r of column c comes from column (c + r) mod 4.
    // Its product word {s, s, 3s, 2s} is rotated right by r + 1 bytes
    // so each coefficient lands in the right output row.
    always_comb
    begin
        aesWordT term;
        int src;
        mixed = roundKey;
        for (int c = 0; c < WORDS_PER_BLOCK; c++)
        begin
            for (int r = 0; r < BYTES_PER_WORD; r++)
            begin
                src = (c + r) % WORDS_PER_BLOCK;
                term = {sReg[src][r], sReg[src][r],
                        sReg[src][r] ^ dReg[src][r], dReg[src][r]};
                for (int j = 0; j < BYTES_PER_WORD; j++)
                begin
                    mixed[c][j] = mixed[c][j] ^ term[(j + 7 - r) % BYTES_PER_WORD];
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        stateOut <= mixed;
    end

    // Valid follows the data through both registers
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            validMid <= 1'b0;
            validOut <= 1'b0;
        end
        else
        begin
            validMid <= validIn;
            validOut <= validMid;
        end
    end

endmodule

//--- hw/aesFinalRound.sv
`timescale 1ns/1ps

module aesFinalRound
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 validIn,
    input  aesTypesPkg::aesBlockT stateIn,
    input  aesTypesPkg::aesBlockT roundKey,
    output aesTypesPkg::aesBlockT stateOut,
    output logic                 validOut
);

    import aesTypesPkg::*;
    import aesTablesPkg::*;

    aesBlockT subReg;
    aesBlockT shifted;
    logic validMid;

    //////////////////////////////////////////////////
    // Cycle 1: SubBytes
    //////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        for (int w = 0; w < WORDS_PER_BLOCK; w++)
        begin
            subReg[w] <= subWord(stateIn[w]);
        end
    end

    //////////////////////////////////////////////////
    // Cycle 2: ShiftRows and AddRoundKey, no MixColumns
    //////////////////////////////////////////////////
    always_comb
    begin
        for (int c = 0; c < WORDS_PER_BLOCK; c++)
        begin
            for (int r = 0; r < BYTES_PER_WORD; r++)
            begin
                shifted[c][r] = subReg[(c + r) % WORDS_PER_BLOCK][r] ^ roundKey[c][r];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        stateOut <= shifted;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            validMid <= 1'b0;
            validOut <= 1'b0;
        end
        else
        begin
            validMid <= validIn;
            validOut <= validMid;
        end
    end

endmodule

//--- hw/aesPipeTop.sv
`timescale 1ns/1ps

`include "aes_settings.svh"

module aesPipeTop
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inValid,
    input  aesTypesPkg::aesBlockT plainText,
    input  aesTypesPkg::aesBlockT cipherKey,
    output logic                 outValid,
    output aesTypesPkg::aesBlockT cipherText
);

    import aesTypesPkg::*;

    // Index 0 is the init stage, index n the output of round n
    aesBlockT stateChain [0:`AES_ROUNDS-1];
    logic validChain [0:`AES_ROUNDS-1];

    // Expanded keys; the last one has no consumer
    aesBlockT keyChain [0:`AES_ROUNDS];
    aesBlockT roundKeys [1:`AES_ROUNDS];

    aesInitStage initStage
    (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .plainText(plainText),
        .cipherKey(cipherKey),
        .stateOut(stateChain[0]),
        .keyOut(keyChain[0]),
        .validOut(validChain[0])
    );

    //////////////////////////////////////////////////
    // Key schedule running alongside the data
    //////////////////////////////////////////////////
    for (genvar n = 1; n <= `AES_ROUNDS; n++)
    begin : genKeySteps
        aesKeyStep #(.STEP_INDEX(n)) keyStep
        (
            .clk(clk),
            .keyIn(keyChain[n-1]),
            .keyOut(keyChain[n]),
            .roundKey(roundKeys[n])
        );
    end

    //////////////////////////////////////////////////
    // Nine full rounds
    //////////////////////////////////////////////////
    for (genvar n = 1; n < `AES_ROUNDS; n++)
    begin : genRounds
        aesRound round
        (
            .clk(clk),
            .rst(rst),
            .validIn(validChain[n-1]),
            .stateIn(stateChain[n-1]),
            .roundKey(roundKeys[n]),
            .stateOut(stateChain[n]),
            .validOut(validChain[n])
        );
    end

    aesFinalRound finalRound
    (
        .clk(clk),
        .rst(rst),
        .validIn(validChain[`AES_ROUNDS-1]),
        .stateIn(stateChain[`AES_ROUNDS-1]),
        .roundKey(roundKeys[`AES_ROUNDS]),
        .stateOut(cipherText),
        .validOut(outValid)
    );

endmodule

//--- sim/aesClockGen.sv
`timescale 1ns/1ps

module aesClockGen
#(
    parameter int PERIOD_NS = 8,
    parameter int RESET_CYCLES = 5
)
(
    input  logic extraReset,
    output logic clk,
    output logic rst
);

    logic powerOnReset;

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Held through the first rising edges, released on a falling edge
    initial
    begin
        powerOnReset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        powerOnReset = 1'b0;
    end

    assign rst = powerOnReset | extraReset;

endmodule

//--- sim/aesPipeTb.sv
`timescale 1ns/1ps

`include "aes_settings.svh"

module aesPipeTb;

    import aesTypesPkg::*;

    typedef struct packed
    {
        aesBlockT plain;
        aesBlockT key;
        aesBlockT cipher;
        int gap;
    } vectorT;

    localparam int DRAIN_TIMEOUT = 100;
    localparam int RESET_TIMEOUT = 20;

    logic clk;
    logic rst;
    logic extraReset;
    logic inValid;
    aesBlockT plainText;
    aesBlockT cipherKey;
    aesBlockT cipherText;
    logic outValid;

    vectorT vectorTable [0:2];

    // Expected results in issue order
    aesBlockT expQueue [$];
    int issueQueue [$];

    int cycleCount = 0;
    int checkCount;
    int errorCount;
    int testErrors;
    aesBlockT monExpected;
    int monIssue;

    aesClockGen clockGen
    (
        .extraReset(extraReset),
        .clk(clk),
        .rst(rst)
    );

    aesPipeTop aesPipeTop_i
    (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .plainText(plainText),
        .cipherKey(cipherKey),
        .outValid(outValid),
        .cipherText(cipherText)
    );

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    task automatic checkValue(input string label, input logic [127:0] actual,
                              input logic [127:0] expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("[ERROR] %0t ns: %s got %h, expected %h", $time, label, actual, expected);
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic sendEntry(input logic [1:0] idx);
        inValid = 1'b1;
        plainText = vectorTable[idx].plain;
        cipherKey = vectorTable[idx].key;
        expQueue.push_back(vectorTable[idx].cipher);
        issueQueue.push_back(cycleCount);
        @(negedge clk);
        inValid = 1'b0;
    endtask

    task automatic idleCycles(input int count);
        inValid = 1'b0;
        repeat (count) @(negedge clk);
    endtask

    task automatic waitForDrain();
        int waited;
        waited = 0;
        while (expQueue.size() > 0 && waited < DRAIN_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (expQueue.size() > 0)
        begin
            errorCount++;
            $display("Timed out after %0d cycles with %0d results never delivered",
                     waited, expQueue.size());
            expQueue.delete();
            issueQueue.delete();
        end
    endtask

    task automatic waitForResetRelease();
        int waited;
        waited = 0;
        while (rst !== 1'b0 && waited < RESET_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (rst !== 1'b0)
        begin
            errorCount++;
            $display("Reset was never released within %0d cycles", RESET_TIMEOUT);
        end
    endtask

    task automatic finishTest(input string name);
        $display("Test %s finished with %0d errors", name, errorCount - testErrors);
        testErrors = errorCount;
    endtask

    //////////////////////////////////////////////////
    // Output monitor
    //////////////////////////////////////////////////
    always @(negedge clk)
    begin
        if (outValid !== 1'b0)
        begin
            if (outValid === 1'b1 && expQueue.size() > 0)
            begin
                monExpected = expQueue.pop_front();
                monIssue = issueQueue.pop_front();
                checkValue("cipherText", cipherText, monExpected);
                checkValue("latency", 128'(cycleCount - monIssue), 128'(`AES_LATENCY));
            end
            else
            begin
                errorCount++;
                $display("outValid was %b at %0t ns with no block waiting for a result",
                         outValid, $time);
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    initial
    begin
        logic [1:0] pick;
        int gap;
        void'($urandom(32'h9751_7ba2));
        extraReset = 1'b0;
        inValid = 1'b0;
        plainText = '0;
        cipherKey = '0;
        checkCount = 0;
        errorCount = 0;
        testErrors = 0;

        // FIPS-197 known answers
        vectorTable[0] = '{128'h00112233445566778899aabbccddeeff,
                           128'h000102030405060708090a0b0c0d0e0f,
                           128'h69c4e0d86a7b0430d8cdb78070b4c55a, 2};
        vectorTable[1] = '{128'h3243f6a8885a308d313198a2e0370734,
                           128'h2b7e151628aed2a6abf7158809cf4f3c,
                           128'h3925841d02dc09fbdc118597196a0b32, 5};
        vectorTable[2] = '{128'h0, 128'h0,
                           128'h66e94bd4ef8a2c3b884cfa59ca342b2e, 1};

        waitForResetRelease();
        idleCycles(30);
        finishTest("1 reset quiet");

        for (logic [1:0] v = 0; v < 2'd3; v++)
        begin
            sendEntry(v);
            idleCycles(vectorTable[v].gap);
            waitForDrain();
        end
        finishTest("2 single known answers");

        sendEntry(2'd0);
        sendEntry(2'd1);
        sendEntry(2'd2);
        waitForDrain();
        finishTest("3 back-to-back streaming");

        for (int n = 0; n < 40; n++)
        begin
            pick = 2'($urandom % 3);
            gap = int'($urandom % 4);
            sendEntry(pick);
            idleCycles(gap);
        end
        waitForDrain();
        finishTest("4 random gaps");

        // Blocks dropped by reset must never show up
        sendEntry(2'd0);
        sendEntry(2'd1);
        sendEntry(2'd2);
        idleCycles(6);
        extraReset = 1'b1;
        expQueue.delete();
        issueQueue.delete();
        idleCycles(3);
        extraReset = 1'b0;
        idleCycles(30);
        sendEntry(2'd1);
        waitForDrain();
        idleCycles(10);
        finishTest("5 reset mid-flight");

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+hw
hw/aesTypesPkg.sv
hw/aesTablesPkg.sv
hw/aesInitStage.sv
hw/aesKeyStep.sv
hw/aesRound.sv
hw/aesFinalRound.sv
hw/aesPipeTop.sv
sim/aesClockGen.sv
sim/aesPipeTb.sv

//--- Makefile
# Verilator flow for the AES-128 pipeline

VERILATOR  ?= verilator
TOP        ?= aesPipeTb
RTL_TOP    ?= aesPipeTop
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 4
VFLAGS     ?= --binary --timing -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT  ?= TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The result is decided by the pass line in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
